// File: flist.f
+incdir+verif
hdl/jtag_tap_pkg.sv
hdl/jtag_instr_pkg.sv
hdl/tap_ctrl_if.sv
hdl/tap_state_machine.sv
hdl/instruction_register.sv
hdl/id_bypass_regs.sv
hdl/tdo_output_mux.sv
hdl/jtag_tap_top.sv
verif/jtag_tap_tb.sv

// File: hdl/id_bypass_regs.sv
// Internal IDCODE and BYPASS data registers
`timescale 1ns/1ps

module id_bypass_regs (
   input  logic                       tck,
   input  logic                       trst_n,
   input  logic                       tdi_i,
   tap_ctrl_if.dr                     tap,
   input  jtag_instr_pkg::instr_sel_t instr_sel_i,
   output logic                       idcode_lsb_o,   // IDCODE scan-out
   output logic                       bypass_bit_o    // BYPASS scan-out
);

   localparam int ID_MSB = jtag_instr_pkg::IDCODE_LEN - 1;

   jtag_instr_pkg::idcode_t idcode_q;
   logic                    bypass_q;
   logic                    idcode_en;
   logic                    bypass_en;

   assign idcode_en = instr_sel_i[jtag_instr_pkg::SEL_IDCODE];
   assign bypass_en = instr_sel_i[jtag_instr_pkg::SEL_BYPASS];

   // IDCODE, shifts toward bit 0
   always_ff @(posedge tck or negedge trst_n)
   begin
      if (!trst_n)
      begin
         idcode_q <= '0;
      end
      else if (tap.capture_dr && idcode_en)
      begin
         idcode_q <= jtag_instr_pkg::IDCODE_VALUE;
      end
      else if (tap.shift_dr && idcode_en)
      begin
         idcode_q <= {tdi_i, idcode_q[ID_MSB:1]};
      end
   end

   // BYPASS, single stage
   always_ff @(posedge tck or negedge trst_n)
   begin
      if (!trst_n)
         bypass_q <= 1'b0;
      else if (tap.capture_dr && bypass_en)
         bypass_q <= 1'b0;              // Leading 0 marks bypass
      else if (tap.shift_dr && bypass_en)
         bypass_q <= tdi_i;
   end

   assign idcode_lsb_o = idcode_q[0];
   assign bypass_bit_o = bypass_q;

endmodule

// File: hdl/instruction_register.sv
// Instruction shift stage, falling-edge active instruction and one-hot decode
`timescale 1ns/1ps

module instruction_register (
   input  logic                     tck,
   input  logic                     trst_n,
   input  logic                     tdi_i,
   tap_ctrl_if.ir                   tap,
   output jtag_instr_pkg::instr_sel_t instr_sel_o,  // Active data register
   output logic                     ir_lsb_o        // Scan-out bit during shift_ir
);

   localparam int IR_MSB = jtag_instr_pkg::IR_LEN - 1;

   jtag_instr_pkg::ir_code_t ir_shift_q;   // Capture/shift stage
   jtag_instr_pkg::ir_code_t ir_active_q;  // Current instruction
   logic                     tck_n;

   assign tck_n = ~tck;

   // Shift stage, tdi enters at the MSB
   always_ff @(posedge tck or negedge trst_n)
   begin
      if (!trst_n)
      begin
         ir_shift_q <= '0;
      end
      else if (tap.capture_ir)
      begin
         ir_shift_q <= jtag_instr_pkg::IR_CAPTURE_VALUE;  // Fixed 00001 for fault checks
      end
      else if (tap.shift_ir)
      begin
         ir_shift_q <= {tdi_i, ir_shift_q[IR_MSB:1]};
      end
   end

   assign ir_lsb_o = ir_shift_q[0];

   // Update on falling edge, half a cycle after the last shift
   always_ff @(posedge tck_n or negedge trst_n)
   begin
      if (!trst_n)
      begin
         ir_active_q <= jtag_instr_pkg::INSTR_IDCODE;
      end
      else if (tap.tlr)
      begin
         ir_active_q <= jtag_instr_pkg::INSTR_IDCODE;  // IDCODE whenever TAP is in reset
      end
      else if (tap.update_ir)
      begin
         ir_active_q <= ir_shift_q;
      end
   end

   // Instruction decode
   always_comb
   begin
      instr_sel_o = '0;
      case (ir_active_q)
         jtag_instr_pkg::INSTR_IDCODE      : instr_sel_o[jtag_instr_pkg::SEL_IDCODE]      = 1'b1;
         jtag_instr_pkg::INSTR_SENS_CTRL   : instr_sel_o[jtag_instr_pkg::SEL_SENS_CTRL]   = 1'b1;
         jtag_instr_pkg::INSTR_SENS_STAT   : instr_sel_o[jtag_instr_pkg::SEL_SENS_STAT]   = 1'b1;
         jtag_instr_pkg::INSTR_REF_COUNTER : instr_sel_o[jtag_instr_pkg::SEL_REF_COUNTER] = 1'b1;
         jtag_instr_pkg::INSTR_BYPASS      : instr_sel_o[jtag_instr_pkg::SEL_BYPASS]      = 1'b1;
         default                           : instr_sel_o[jtag_instr_pkg::SEL_BYPASS]      = 1'b1;
      endcase
   end

endmodule

// File: hdl/jtag_instr_pkg.sv
// Device instruction set, IDCODE value and one-hot register select type
package jtag_instr_pkg;

   // Instruction register
   localparam int IR_LEN = 5;
   typedef logic [IR_LEN-1:0] ir_code_t;

   localparam ir_code_t IR_CAPTURE_VALUE  = 5'b00001;  // Loaded in capture_ir

   localparam ir_code_t INSTR_IDCODE      = 5'b00010;  // Default after reset
   localparam ir_code_t INSTR_SENS_CTRL   = 5'b00100;  // Sensor control DR
   localparam ir_code_t INSTR_REF_COUNTER = 5'b01000;  // Reference counter DR
   localparam ir_code_t INSTR_SENS_STAT   = 5'b01100;  // Sensor status DR
   localparam ir_code_t INSTR_BYPASS      = 5'b11111;

   // Device identification
   localparam int IDCODE_LEN = 32;
   typedef logic [IDCODE_LEN-1:0] idcode_t;
   localparam idcode_t IDCODE_VALUE = 32'hBA20A005;   // LSB must stay 1

   // One-hot data register select, bit positions
   localparam int SEL_IDCODE      = 0;
   localparam int SEL_BYPASS      = 1;
   localparam int SEL_SENS_CTRL   = 2;
   localparam int SEL_SENS_STAT   = 3;
   localparam int SEL_REF_COUNTER = 4;
   localparam int SEL_W           = 5;

   typedef logic [SEL_W-1:0] instr_sel_t;

endpackage

// File: hdl/jtag_tap_pkg.sv
// TAP controller state encoding and state register width
package jtag_tap_pkg;

   ////////////////////////////////////////////////////////////////////
   // State register sizing
   ////////////////////////////////////////////////////////////////////

   localparam int TAP_NUM_STATES = 16;                      // IEEE 1149.1 state count
   localparam int TAP_STATE_W    = $clog2(TAP_NUM_STATES);  // 4 bits, fully packed

   ////////////////////////////////////////////////////////////////////
   // TAP states
   ////////////////////////////////////////////////////////////////////

   // DR column first, then IR column
   typedef enum logic [TAP_STATE_W-1:0] {
      test_logic_reset = 4'h0,  // Reset state, IDCODE active
      run_test_idle    = 4'h1,
      select_dr_scan   = 4'h2,
      capture_dr       = 4'h3,  // Parallel load of DR
      shift_dr         = 4'h4,  // Serial DR path tdi -> tdo
      exit1_dr         = 4'h5,
      pause_dr         = 4'h6,  // Shift held off
      exit2_dr         = 4'h7,
      update_dr        = 4'h8,
      select_ir_scan   = 4'h9,
      capture_ir       = 4'hA,  // Fixed pattern into IR
      shift_ir         = 4'hB,
      exit1_ir         = 4'hC,
      pause_ir         = 4'hD,
      exit2_ir         = 4'hE,
      update_ir        = 4'hF   // New instruction takes effect
   } tap_state_e;

endpackage

// File: hdl/jtag_tap_top.sv
// JTAG TAP top level with pad ports, sensor DR selects and DR strobes
`timescale 1ns/1ps

module jtag_tap_top (
   // Test port
   input  logic tck,
   input  logic trst_n,
   input  logic tms_i,
   input  logic tdi_i,
   output logic tdo_o,
   output logic tdo_en_n_o,           // Active low pad enable

   // Scan-out from external sensor DRs
   input  logic sens_ctrl_tdo_i,
   input  logic sens_stat_tdo_i,
   input  logic ref_counter_tdo_i,

   // DR state strobes for the external registers
   output logic capture_dr_o,
   output logic shift_dr_o,
   output logic pause_dr_o,
   output logic update_dr_o,

   // Register selects
   output logic idcode_select_o,
   output logic bypass_select_o,
   output logic sens_ctrl_select_o,
   output logic sens_stat_select_o,
   output logic ref_counter_select_o
);

   jtag_instr_pkg::instr_sel_t instr_sel;
   logic                       ir_lsb;
   logic                       idcode_lsb;
   logic                       bypass_bit;

   tap_ctrl_if tap_if ();

   ////////////////////////////////////////////////////////////////////
   // Controller, IR and internal DRs
   ////////////////////////////////////////////////////////////////////

   tap_state_machine tap_state_machine_inst (
      .tck    (tck),
      .trst_n (trst_n),
      .tms_i  (tms_i),
      .tap    (tap_if.ctrl)
   );

   instruction_register instruction_register_inst (
      .tck         (tck),
      .trst_n      (trst_n),
      .tdi_i       (tdi_i),
      .tap         (tap_if.ir),
      .instr_sel_o (instr_sel),
      .ir_lsb_o    (ir_lsb)
   );

   id_bypass_regs id_bypass_regs_inst (
      .tck          (tck),
      .trst_n       (trst_n),
      .tdi_i        (tdi_i),
      .tap          (tap_if.dr),
      .instr_sel_i  (instr_sel),
      .idcode_lsb_o (idcode_lsb),
      .bypass_bit_o (bypass_bit)
   );

   tdo_output_mux tdo_output_mux_inst (
      .tck               (tck),
      .trst_n            (trst_n),
      .tap               (tap_if.out),
      .instr_sel_i       (instr_sel),
      .ir_lsb_i          (ir_lsb),
      .idcode_lsb_i      (idcode_lsb),
      .bypass_bit_i      (bypass_bit),
      .sens_ctrl_tdo_i   (sens_ctrl_tdo_i),
      .sens_stat_tdo_i   (sens_stat_tdo_i),
      .ref_counter_tdo_i (ref_counter_tdo_i),
      .tdo_o             (tdo_o),
      .tdo_en_n_o        (tdo_en_n_o)
   );

   // DR strobes out to the pads
   assign capture_dr_o = tap_if.capture_dr;
   assign shift_dr_o   = tap_if.shift_dr;
   assign pause_dr_o   = tap_if.pause_dr;
   assign update_dr_o  = tap_if.update_dr;

   // One-hot select spread onto ports
   assign idcode_select_o      = instr_sel[jtag_instr_pkg::SEL_IDCODE];
   assign bypass_select_o      = instr_sel[jtag_instr_pkg::SEL_BYPASS];
   assign sens_ctrl_select_o   = instr_sel[jtag_instr_pkg::SEL_SENS_CTRL];
   assign sens_stat_select_o   = instr_sel[jtag_instr_pkg::SEL_SENS_STAT];
   assign ref_counter_select_o = instr_sel[jtag_instr_pkg::SEL_REF_COUNTER];

endmodule

// File: hdl/tap_ctrl_if.sv
// Decoded TAP state strobes with controller and consumer modports
`timescale 1ns/1ps

interface tap_ctrl_if;

   logic tlr;         // In test_logic_reset
   logic capture_dr;
   logic shift_dr;
   logic pause_dr;
   logic update_dr;
   logic capture_ir;
   logic shift_ir;
   logic update_ir;
   logic shift_any;   // Either shift state, drives TDO enable

   // State machine side
   modport ctrl (output tlr, capture_dr, shift_dr, pause_dr, update_dr,
                 capture_ir, shift_ir, update_ir, shift_any);

   // Instruction register
   modport ir   (input tlr, capture_ir, shift_ir, update_ir);

   // Internal data registers
   modport dr   (input capture_dr, shift_dr);

   // TDO stage
   modport out  (input shift_ir, shift_any);

endinterface

// File: hdl/tap_state_machine.sv
// TAP controller with next-state table, state register and state strobes
`timescale 1ns/1ps

module tap_state_machine (
   input  logic            tck,
   input  logic            trst_n,
   input  logic            tms_i,     // Sampled on rising tck
   tap_ctrl_if.ctrl        tap
);

   jtag_tap_pkg::tap_state_e state_q;
   jtag_tap_pkg::tap_state_e state_d;

   //////////////////////////////////////////////////////////////////////
   // State register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge tck or negedge trst_n)
   begin
      if (!trst_n)
      begin
         state_q <= jtag_tap_pkg::test_logic_reset;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Next state, standard 1149.1 transitions
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (state_q)
         // tms high holds reset, low goes to idle
         jtag_tap_pkg::test_logic_reset :
            state_d = tms_i ? jtag_tap_pkg::test_logic_reset : jtag_tap_pkg::run_test_idle;
         jtag_tap_pkg::run_test_idle :
            state_d = tms_i ? jtag_tap_pkg::select_dr_scan : jtag_tap_pkg::run_test_idle;

         // DR column
         jtag_tap_pkg::select_dr_scan :
            state_d = tms_i ? jtag_tap_pkg::select_ir_scan : jtag_tap_pkg::capture_dr;
         jtag_tap_pkg::capture_dr :
            state_d = tms_i ? jtag_tap_pkg::exit1_dr : jtag_tap_pkg::shift_dr;
         jtag_tap_pkg::shift_dr :
            state_d = tms_i ? jtag_tap_pkg::exit1_dr : jtag_tap_pkg::shift_dr;
         jtag_tap_pkg::exit1_dr :
            state_d = tms_i ? jtag_tap_pkg::update_dr : jtag_tap_pkg::pause_dr;
         jtag_tap_pkg::pause_dr :
            state_d = tms_i ? jtag_tap_pkg::exit2_dr : jtag_tap_pkg::pause_dr;
         jtag_tap_pkg::exit2_dr :
            state_d = tms_i ? jtag_tap_pkg::update_dr : jtag_tap_pkg::shift_dr;
         jtag_tap_pkg::update_dr :
            state_d = tms_i ? jtag_tap_pkg::select_dr_scan : jtag_tap_pkg::run_test_idle;

         // IR column
         jtag_tap_pkg::select_ir_scan :
            state_d = tms_i ? jtag_tap_pkg::test_logic_reset : jtag_tap_pkg::capture_ir;
         jtag_tap_pkg::capture_ir :
            state_d = tms_i ? jtag_tap_pkg::exit1_ir : jtag_tap_pkg::shift_ir;
         jtag_tap_pkg::shift_ir :
            state_d = tms_i ? jtag_tap_pkg::exit1_ir : jtag_tap_pkg::shift_ir;
         jtag_tap_pkg::exit1_ir :
            state_d = tms_i ? jtag_tap_pkg::update_ir : jtag_tap_pkg::pause_ir;
         jtag_tap_pkg::pause_ir :
            state_d = tms_i ? jtag_tap_pkg::exit2_ir : jtag_tap_pkg::pause_ir;
         jtag_tap_pkg::exit2_ir :
            state_d = tms_i ? jtag_tap_pkg::update_ir : jtag_tap_pkg::shift_ir;
         jtag_tap_pkg::update_ir :
            state_d = tms_i ? jtag_tap_pkg::select_dr_scan : jtag_tap_pkg::run_test_idle;

         default : state_d = jtag_tap_pkg::test_logic_reset;  // Illegal code recovers
      endcase
   end

   // Strobes straight from the state register, same cycle as state
   assign tap.tlr        = (state_q == jtag_tap_pkg::test_logic_reset);
   assign tap.capture_dr = (state_q == jtag_tap_pkg::capture_dr);
   assign tap.shift_dr   = (state_q == jtag_tap_pkg::shift_dr);
   assign tap.pause_dr   = (state_q == jtag_tap_pkg::pause_dr);
   assign tap.update_dr  = (state_q == jtag_tap_pkg::update_dr);
   assign tap.capture_ir = (state_q == jtag_tap_pkg::capture_ir);
   assign tap.shift_ir   = (state_q == jtag_tap_pkg::shift_ir);
   assign tap.update_ir  = (state_q == jtag_tap_pkg::update_ir);
   assign tap.shift_any  = (state_q == jtag_tap_pkg::shift_dr) ||
                           (state_q == jtag_tap_pkg::shift_ir);

endmodule

// File: hdl/tdo_output_mux.sv
// Scan-out select, falling-edge TDO register and active-low TDO enable
`timescale 1ns/1ps

module tdo_output_mux (
   input  logic                       tck,
   input  logic                       trst_n,
   tap_ctrl_if.out                    tap,
   input  jtag_instr_pkg::instr_sel_t instr_sel_i,
   input  logic                       ir_lsb_i,
   input  logic                       idcode_lsb_i,
   input  logic                       bypass_bit_i,
   input  logic                       sens_ctrl_tdo_i,    // External sensor DRs
   input  logic                       sens_stat_tdo_i,
   input  logic                       ref_counter_tdo_i,
   output logic                       tdo_o,
   output logic                       tdo_en_n_o
);

   logic dr_bit;     // Selected DR scan bit
   logic scan_bit;
   logic tck_n;
   logic tdo_q;

   assign tck_n = ~tck;

   // One-hot AND-OR, exactly one select is set
   assign dr_bit = (instr_sel_i[jtag_instr_pkg::SEL_IDCODE]      & idcode_lsb_i)    |
                   (instr_sel_i[jtag_instr_pkg::SEL_BYPASS]      & bypass_bit_i)    |
                   (instr_sel_i[jtag_instr_pkg::SEL_SENS_CTRL]   & sens_ctrl_tdo_i) |
                   (instr_sel_i[jtag_instr_pkg::SEL_SENS_STAT]   & sens_stat_tdo_i) |
                   (instr_sel_i[jtag_instr_pkg::SEL_REF_COUNTER] & ref_counter_tdo_i);

   assign scan_bit = tap.shift_ir ? ir_lsb_i : dr_bit;  // IR path wins in shift_ir

   // TDO changes on falling tck, stable at the next rising edge
   always_ff @(posedge tck_n or negedge trst_n)
   begin
      if (!trst_n)
         tdo_q <= 1'b0;
      else
         tdo_q <= scan_bit;
   end

   assign tdo_o      = tdo_q;
   assign tdo_en_n_o = ~tap.shift_any;  // Pad driven only while shifting

endmodule

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the JTAG TAP testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
   --top-module jtag_tap_tb -o jtag_tap_sim
if [ $? -ne 0 ]
then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/jtag_tap_sim > "$LOG" 2>&1
if [ $? -ne 0 ]
then
   cat "$LOG"
   echo "Simulation run failed, see $LOG"
   exit 1
fi

cat "$LOG"
if grep -q 'All tests passed!' "$LOG"
then
   echo "PASS"
   exit 0
fi
echo "FAIL, see $LOG"
exit 1

// File: verif/jtag_tap_tasks.svh
// Error counters, compare tasks and TAP walking tasks for the TAP testbench
`ifndef JTAG_TAP_TASKS_SVH
`define JTAG_TAP_TASKS_SVH

int value_errors   = 0;
int timeout_errors = 0;

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_word(input string name, input jtag_instr_pkg::idcode_t exp,
                          input jtag_instr_pkg::idcode_t act);
   if (act !== exp)
   begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      value_errors++;
   end
endtask

task automatic check_ir(input string name, input jtag_instr_pkg::ir_code_t exp,
                        input jtag_instr_pkg::ir_code_t act);
   if (act !== exp)
   begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      value_errors++;
   end
endtask

task automatic check_sel(input string name, input jtag_instr_pkg::instr_sel_t exp,
                         input jtag_instr_pkg::instr_sel_t act);
   if (act !== exp)
   begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      value_errors++;
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
   begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      value_errors++;
   end
endtask

//////////////////////////////////////////////////////////////////////
// TAP walking
//////////////////////////////////////////////////////////////////////

// One tck cycle, returns 1 ns before the next rising edge
task automatic tap_step(input logic tms, input logic tdi);
   @(posedge tck);
   #2;
   tms_i = tms;   // Taken at the next rising edge
   tdi_i = tdi;
   #17;
endtask

// Idle cycle used to change the sensor levels
task automatic drive_sensors(input logic [2:0] lv);
   @(posedge tck);
   #2;
   sens_ctrl_tdo_i   = lv[2];
   sens_stat_tdo_i   = lv[1];
   ref_counter_tdo_i = lv[0];
   #17;
endtask

task automatic tap_reset();
   repeat (5) tap_step(1'b1, 1'b0);
   tap_step(1'b0, 1'b0);              // Out of reset into idle
endtask

task automatic goto_shift_ir(input string name);
   tap_step(1'b1, 1'b0);              // Window is idle
   check_bit({name, " idle tdo_en_n"}, 1'b1, tdo_en_n_o);
   tap_step(1'b1, 1'b0);
   tap_step(1'b0, 1'b0);
   tap_step(1'b0, 1'b0);              // Capture_ir, shift follows
endtask

task automatic goto_shift_dr(input string name);
   tap_step(1'b1, 1'b0);
   check_bit({name, " idle tdo_en_n"}, 1'b1, tdo_en_n_o);
   tap_step(1'b0, 1'b0);
   tap_step(1'b0, 1'b0);              // Window is capture_dr
   check_bit({name, " capture_dr"}, 1'b1, capture_dr_o);
endtask

// Exit1 -> pause, hold until the strobe shows, then back to shift
task automatic hold_in_pause(input string name);
   int cnt;
   cnt = 0;
   tap_step(1'b0, 1'b0);
   tap_step(1'b0, 1'b0);
   while (!pause_dr_o && cnt < 100)
   begin
      tap_step(1'b0, 1'b0);
      cnt++;
   end
   if (cnt == 100)
   begin
      $display("Timeout in %s waiting for pause_dr_o", name);
      timeout_errors++;
   end
   tap_step(1'b1, 1'b0);              // Pause to exit2
   tap_step(1'b0, 1'b0);              // Exit2 back to shift
endtask

// Shift n bits LSB first, then update and idle
task automatic scan_bits(input string name, input int n, input jtag_instr_pkg::idcode_t pat,
                         input int pause_at, input bit is_dr,
                         output jtag_instr_pkg::idcode_t got);
   logic leave;
   got = '0;
   for (int i = 0; i < n; i++)
   begin
      leave = (i == n - 1) || (i == pause_at - 1);
      tap_step(leave, pat[i]);
      got[i] = tdo_o;                 // Bit i valid before this edge
      check_bit({name, " tdo_en_n"}, 1'b0, tdo_en_n_o);
      if (is_dr)
         check_bit({name, " shift_dr"}, 1'b1, shift_dr_o);
      if (i == pause_at - 1 && i != n - 1)
         hold_in_pause(name);
   end
   tap_step(1'b1, 1'b0);              // Exit1 to update
   tap_step(1'b0, 1'b0);              // Window is update
   if (is_dr)
      check_bit({name, " update_dr"}, 1'b1, update_dr_o);
endtask

`endif

// File: verif/jtag_tap_tb.sv
// JTAG TAP testbench with clock, reset, DUT instance, stimulus table and row loop
`timescale 1ns/1ps

module jtag_tap_tb;

   logic tck;
   logic trst_n;
   logic tms_i;
   logic tdi_i;
   logic sens_ctrl_tdo_i;
   logic sens_stat_tdo_i;
   logic ref_counter_tdo_i;
   logic tdo_o;
   logic tdo_en_n_o;
   logic capture_dr_o;
   logic shift_dr_o;
   logic pause_dr_o;
   logic update_dr_o;
   logic idcode_select_o;
   logic bypass_select_o;
   logic sens_ctrl_select_o;
   logic sens_stat_select_o;
   logic ref_counter_select_o;

   // One table row
   typedef struct {
      string                      name;
      bit                         do_reset;   // tap_reset first
      bit                         load_ir;
      jtag_instr_pkg::ir_code_t   ir;
      int                         len;        // DR scan length
      jtag_instr_pkg::idcode_t    tdi;
      logic [2:0]                 sens;       // Ctrl, stat, ref levels
      int                         pause_at;   // 0 for no pause
      jtag_instr_pkg::idcode_t    exp_word;
      jtag_instr_pkg::instr_sel_t exp_sel;
   } row_t;

   row_t rows[$];

   `include "jtag_tap_tasks.svh"

   jtag_tap_top jtag_tap_top_inst (.*);

   initial
   begin
      tck = 1'b0;
      forever #10 tck = ~tck;
   end

   function automatic jtag_instr_pkg::idcode_t len_mask(input int n);
      jtag_instr_pkg::idcode_t m;
      m = '0;
      for (int i = 0; i < n; i++)
         m[i] = 1'b1;
      return m;
   endfunction

   function automatic jtag_instr_pkg::instr_sel_t one_hot(input int idx);
      jtag_instr_pkg::instr_sel_t s;
      s = '0;
      s[idx] = 1'b1;
      return s;
   endfunction

   // Select ports gathered back into one-hot form
   function automatic jtag_instr_pkg::instr_sel_t read_selects();
      jtag_instr_pkg::instr_sel_t s;
      s = '0;
      s[jtag_instr_pkg::SEL_IDCODE]      = idcode_select_o;
      s[jtag_instr_pkg::SEL_BYPASS]      = bypass_select_o;
      s[jtag_instr_pkg::SEL_SENS_CTRL]   = sens_ctrl_select_o;
      s[jtag_instr_pkg::SEL_SENS_STAT]   = sens_stat_select_o;
      s[jtag_instr_pkg::SEL_REF_COUNTER] = ref_counter_select_o;
      return s;
   endfunction

   initial
   begin
      row_t                    r;
      jtag_instr_pkg::idcode_t rnd;
      jtag_instr_pkg::idcode_t out;
      int                      cnt;

      void'($urandom(32'h67f7));
      tms_i             = 1'b1;
      tdi_i             = 1'b0;
      sens_ctrl_tdo_i   = 1'b0;
      sens_stat_tdo_i   = 1'b0;
      ref_counter_tdo_i = 1'b0;
      trst_n            = 1'b0;

      ////////////////////////////////////////////////////////////////////
      // Stimulus table
      ////////////////////////////////////////////////////////////////////
      rnd = $urandom();
      r = '{"idcode_after_reset", 1'b0, 1'b0, jtag_instr_pkg::INSTR_IDCODE, 32, rnd, 3'b111, 0,
            jtag_instr_pkg::IDCODE_VALUE, one_hot(jtag_instr_pkg::SEL_IDCODE)};
      rows.push_back(r);
      rnd = $urandom();
      r = '{"bypass", 1'b0, 1'b1, jtag_instr_pkg::INSTR_BYPASS, 16, rnd, 3'b111, 0,
            (rnd << 1) & len_mask(16), one_hot(jtag_instr_pkg::SEL_BYPASS)};
      rows.push_back(r);
      r = '{"reset_to_idcode", 1'b1, 1'b0, jtag_instr_pkg::INSTR_IDCODE, 32, rnd, 3'b000, 0,
            jtag_instr_pkg::IDCODE_VALUE, one_hot(jtag_instr_pkg::SEL_IDCODE)};
      rows.push_back(r);
      r = '{"sens_ctrl", 1'b0, 1'b1, jtag_instr_pkg::INSTR_SENS_CTRL, 12, rnd, 3'b100, 5,
            len_mask(12), one_hot(jtag_instr_pkg::SEL_SENS_CTRL)};
      rows.push_back(r);
      r = '{"sens_stat", 1'b0, 1'b1, jtag_instr_pkg::INSTR_SENS_STAT, 8, rnd, 3'b101, 0,
            '0, one_hot(jtag_instr_pkg::SEL_SENS_STAT)};
      rows.push_back(r);
      r = '{"ref_counter", 1'b0, 1'b1, jtag_instr_pkg::INSTR_REF_COUNTER, 20, rnd, 3'b011, 7,
            len_mask(20), one_hot(jtag_instr_pkg::SEL_REF_COUNTER)};
      rows.push_back(r);
      rnd = $urandom();
      r = '{"unknown_code", 1'b0, 1'b1, 5'b10101, 9, rnd, 3'b111, 3,
            (rnd << 1) & len_mask(9), one_hot(jtag_instr_pkg::SEL_BYPASS)};
      rows.push_back(r);
      r = '{"idcode_reload", 1'b0, 1'b1, jtag_instr_pkg::INSTR_IDCODE, 32, rnd, 3'b111, 16,
            jtag_instr_pkg::IDCODE_VALUE, one_hot(jtag_instr_pkg::SEL_IDCODE)};
      rows.push_back(r);

      // Reset for 16 cycles, then wait for the reset levels
      repeat (16) @(posedge tck);
      #2;
      trst_n = 1'b1;
      cnt = 0;
      tap_step(1'b1, 1'b0);
      while (!(idcode_select_o && tdo_en_n_o) && cnt < 100)
      begin
         tap_step(1'b1, 1'b0);
         cnt++;
      end
      if (cnt == 100)
      begin
         $display("Timeout waiting for the TAP to come out of reset");
         timeout_errors++;
      end
      check_bit("reset tdo", 1'b0, tdo_o);
      check_bit("reset capture_dr", 1'b0, capture_dr_o);
      check_bit("reset shift_dr", 1'b0, shift_dr_o);
      check_bit("reset pause_dr", 1'b0, pause_dr_o);
      check_bit("reset update_dr", 1'b0, update_dr_o);
      tap_step(1'b0, 1'b0);           // Into idle

      foreach (rows[k])
      begin
         drive_sensors(rows[k].sens);
         if (rows[k].do_reset)
            tap_reset();
         if (rows[k].load_ir)
         begin
            goto_shift_ir(rows[k].name);
            scan_bits(rows[k].name, jtag_instr_pkg::IR_LEN,
                      jtag_instr_pkg::idcode_t'(rows[k].ir), 0, 1'b0, out);
            check_ir({rows[k].name, " ir capture"}, jtag_instr_pkg::IR_CAPTURE_VALUE,
                     out[jtag_instr_pkg::IR_LEN-1:0]);
         end
         check_sel({rows[k].name, " select"}, rows[k].exp_sel, read_selects());
         goto_shift_dr(rows[k].name);
         scan_bits(rows[k].name, rows[k].len, rows[k].tdi, rows[k].pause_at, 1'b1, out);
         check_word({rows[k].name, " dr scan"}, rows[k].exp_word, out);
      end

      $display("Rows %0d, value errors %0d, timeouts %0d",
               rows.size(), value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule
